// File: flist.f
+incdir+include
rtl/serv_pkg.sv
rtl/serv_ifs.sv
rtl/serv_state.sv
rtl/serv_decode.sv
rtl/serv_immdec.sv
rtl/serv_alu.sv
rtl/serv_ctrl.sv
rtl/serv_top.sv
tests/serv_tb.sv

// File: include/serv_params.svh
`ifndef SERV_PARAMS_SVH
`define SERV_PARAMS_SVH

// Datapath and register file geometry
`define SERV_XLEN     32
`define SERV_REG_AW   5
`define SERV_RESET_PC 32'h0000_0000

// Major opcodes in instruction bits 6:2
`define SERV_OP_IMM   5'b00100
`define SERV_OP_REG   5'b01100
`define SERV_OP_LUI   5'b01101

// funct3 codes of the supported ALU operations
`define SERV_F3_ADD   3'b000
`define SERV_F3_XOR   3'b100
`define SERV_F3_OR    3'b110
`define SERV_F3_AND   3'b111

`endif

// File: rtl/serv_alu.sv
`timescale 1ns/100ps

module serv_alu (
   input  logic   clk,
   input  logic   i_rs1,
   input  logic   i_rs2,
   input  logic   i_imm,
   decode_if.user dec,
   count_if.user  cnt,
   output logic   o_rd
);

   logic op_b;
   logic cin;
   logic sum;
   logic carry;

   // Inverted operand plus carry-in of one gives subtraction
   assign op_b = (dec.op_b_imm ? i_imm : i_rs2) ^ dec.sub;
   assign cin  = cnt.cnt0 ? dec.sub : carry;
   assign sum  = i_rs1 ^ op_b ^ cin;

   always_ff @(posedge clk) begin
      if (cnt.cnt_en) begin
         carry <= (i_rs1 & op_b) | (cin & (i_rs1 ^ op_b));
      end
   end

   always_comb begin
      case (dec.alu_op)
         serv_pkg::ALU_ADD: o_rd = sum;
         serv_pkg::ALU_XOR: o_rd = i_rs1 ^ op_b;
         serv_pkg::ALU_OR:  o_rd = i_rs1 | op_b;
         serv_pkg::ALU_AND: o_rd = i_rs1 & op_b;
         default:           o_rd = sum;
      endcase
   end

endmodule

// File: rtl/serv_ctrl.sv
`timescale 1ns/100ps
`include "serv_params.svh"

module serv_ctrl (
   input  logic            clk,
   input  logic            i_rst_n,
   count_if.user           cnt,
   output serv_pkg::word_t o_ibus_adr
);

   serv_pkg::word_t pc_sr;
   logic            inc;
   logic            cin;
   logic            sum;
   logic            carry;

   // PC + 4 is a single one added at bit 2
   assign inc = (cnt.cnt == serv_pkg::bit_cnt_t'(2));
   assign cin = carry & ~cnt.cnt0;
   assign sum = pc_sr[0] ^ inc ^ cin;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_sr      <= `SERV_RESET_PC;
         o_ibus_adr <= `SERV_RESET_PC;
         carry      <= 1'b0;
      end else if (cnt.cnt_en) begin
         pc_sr <= {sum, pc_sr[`SERV_XLEN-1:1]};
         carry <= (pc_sr[0] & inc) | (cin & (pc_sr[0] ^ inc));
         // Last bit completes the new PC
         if (cnt.cnt_done) begin
            o_ibus_adr <= {sum, pc_sr[`SERV_XLEN-1:1]};
         end
      end
   end

endmodule

// File: rtl/serv_decode.sv
`timescale 1ns/100ps
`include "serv_params.svh"

module serv_decode (
   input  logic            clk,
   input  logic            i_ibus_ack,
   input  serv_pkg::word_t i_ibus_rdt,
   decode_if.dec           dec
);

   logic [4:0]          opcode;
   logic [2:0]          funct3;
   logic                is_imm;
   logic                is_reg;
   logic                is_lui;
   logic                f3_ok;
   logic                supported;
   serv_pkg::reg_addr_t rd;
   serv_pkg::alu_op_t   alu_op_nxt;

   assign opcode = i_ibus_rdt[6:2];
   assign funct3 = i_ibus_rdt[14:12];
   assign rd     = i_ibus_rdt[11:7];

   assign is_imm = (opcode == `SERV_OP_IMM);
   assign is_reg = (opcode == `SERV_OP_REG);
   assign is_lui = (opcode == `SERV_OP_LUI);

   always_comb begin
      f3_ok      = 1'b1;
      alu_op_nxt = serv_pkg::ALU_ADD;
      case (funct3)
         `SERV_F3_ADD: alu_op_nxt = serv_pkg::ALU_ADD;
         `SERV_F3_XOR: alu_op_nxt = serv_pkg::ALU_XOR;
         `SERV_F3_OR:  alu_op_nxt = serv_pkg::ALU_OR;
         `SERV_F3_AND: alu_op_nxt = serv_pkg::ALU_AND;
         default:      f3_ok      = 1'b0;
      endcase
      // LUI adds the immediate to x0
      if (is_lui) begin
         alu_op_nxt = serv_pkg::ALU_ADD;
      end
   end

   // Everything else runs as a no-op
   assign supported = ((is_imm | is_reg) & f3_ok) | is_lui;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         dec.rs1_addr <= is_lui ? '0 : i_ibus_rdt[19:15];
         dec.rs2_addr <= i_ibus_rdt[24:20];
         dec.rd_addr  <= rd;
         dec.rd_wen   <= supported & (rd != '0);
         dec.alu_op   <= alu_op_nxt;
         dec.sub      <= is_reg & i_ibus_rdt[30] & (funct3 == `SERV_F3_ADD);
         dec.op_b_imm <= ~is_reg;
         dec.utype    <= is_lui;
      end
   end

endmodule

// File: rtl/serv_ifs.sv
`timescale 1ns/100ps

// Control bundle from the decoder
interface decode_if;
   serv_pkg::reg_addr_t rs1_addr;
   serv_pkg::reg_addr_t rs2_addr;
   serv_pkg::reg_addr_t rd_addr;
   logic                rd_wen;
   serv_pkg::alu_op_t   alu_op;
   logic                sub;
   logic                op_b_imm;
   logic                utype;

   modport dec (
      output rs1_addr, rs2_addr, rd_addr, rd_wen, alu_op, sub, op_b_imm, utype
   );

   modport user (
      input rs1_addr, rs2_addr, rd_addr, rd_wen, alu_op, sub, op_b_imm, utype
   );
endinterface

// Bit counter state shared by the serial units
interface count_if;
   logic                cnt_en;
   serv_pkg::bit_cnt_t  cnt;
   logic                cnt0;
   logic                cnt_done;

   modport gen (
      output cnt_en, cnt, cnt0, cnt_done
   );

   modport user (
      input cnt_en, cnt, cnt0, cnt_done
   );
endinterface

// File: rtl/serv_immdec.sv
`timescale 1ns/100ps

module serv_immdec (
   input  logic            clk,
   input  logic            i_ibus_ack,
   input  serv_pkg::word_t i_ibus_rdt,
   decode_if.user          dec,
   count_if.user           cnt,
   output logic            o_imm
);

   // Instruction bits 31:12 with the I-type field in the upper 12
   logic [19:0] imm_sr;
   logic        upper;
   logic        shift_en;

   // U-type fills bits 0 to 11 with zeros
   assign upper    = (cnt.cnt >= serv_pkg::bit_cnt_t'(12));
   assign shift_en = cnt.cnt_en & (~dec.utype | upper);

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm_sr <= i_ibus_rdt[31:12];
      end else if (shift_en) begin
         // Top bit is the sign and stays put
         imm_sr <= {imm_sr[19], imm_sr[19:1]};
      end
   end

   // Bit 8 of the register is instruction bit 20
   assign o_imm = dec.utype ? (upper & imm_sr[0]) : imm_sr[8];

endmodule

// File: rtl/serv_pkg.sv
`include "serv_params.svh"

package serv_pkg;

   // Instruction, address or register value
   typedef logic [`SERV_XLEN-1:0] word_t;

   // Register index
   typedef logic [`SERV_REG_AW-1:0] reg_addr_t;

   // Bit position within a run
   typedef logic [$clog2(`SERV_XLEN)-1:0] bit_cnt_t;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_t;

   // Fetch, register read request, wait for ready, serial run
   typedef enum logic [1:0] {
      ST_FETCH,
      ST_REQ,
      ST_WAIT,
      ST_RUN
   } state_t;

endpackage

// File: rtl/serv_state.sv
`timescale 1ns/100ps
`include "serv_params.svh"

module serv_state (
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_ibus_ack,
   input  logic    i_rf_ready,
   output logic    o_ibus_cyc,
   output logic    o_rf_rreq,
   output logic    o_wen0,
   decode_if.user  dec,
   count_if.gen    cnt
);

   serv_pkg::state_t   state;
   serv_pkg::state_t   state_nxt;
   serv_pkg::bit_cnt_t bit_cnt;
   logic               running;
   logic               last_bit;

   assign running  = (state == serv_pkg::ST_RUN);
   assign last_bit = running & (bit_cnt == serv_pkg::bit_cnt_t'(`SERV_XLEN - 1));

   assign cnt.cnt_en   = running;
   assign cnt.cnt      = bit_cnt;
   assign cnt.cnt0     = running & (bit_cnt == '0);
   assign cnt.cnt_done = last_bit;

   assign o_ibus_cyc = (state == serv_pkg::ST_FETCH);
   assign o_rf_rreq  = (state == serv_pkg::ST_REQ);

   // x0 writes are already filtered out in decode
   assign o_wen0 = running & dec.rd_wen;

   always_comb begin
      state_nxt = state;
      case (state)
         serv_pkg::ST_FETCH: begin
            if (i_ibus_ack) begin
               state_nxt = serv_pkg::ST_REQ;
            end
         end
         serv_pkg::ST_REQ: begin
            state_nxt = serv_pkg::ST_WAIT;
         end
         serv_pkg::ST_WAIT: begin
            if (i_rf_ready) begin
               state_nxt = serv_pkg::ST_RUN;
            end
         end
         serv_pkg::ST_RUN: begin
            if (last_bit) begin
               state_nxt = serv_pkg::ST_FETCH;
            end
         end
         default: begin
            state_nxt = serv_pkg::ST_FETCH;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state   <= serv_pkg::ST_FETCH;
         bit_cnt <= '0;
      end else begin
         state <= state_nxt;
         // Wraps back to zero after bit 31
         if (running) begin
            bit_cnt <= bit_cnt + serv_pkg::bit_cnt_t'(1);
         end
      end
   end

endmodule

// File: rtl/serv_top.sv
`timescale 1ns/100ps

module serv_top (
   input  logic                clk,
   input  logic                i_rst_n,
   // Instruction fetch
   output serv_pkg::word_t     o_ibus_adr,
   output logic                o_ibus_cyc,
   input  serv_pkg::word_t     i_ibus_rdt,
   input  logic                i_ibus_ack,
   // Register file
   output logic                o_rf_rreq,
   input  logic                i_rf_ready,
   output serv_pkg::reg_addr_t o_rreg0,
   output serv_pkg::reg_addr_t o_rreg1,
   output serv_pkg::reg_addr_t o_wreg0,
   input  logic                i_rdata0,
   input  logic                i_rdata1,
   output logic                o_wen0,
   output logic                o_wdata0
);

   decode_if dec_bus ();
   count_if  cnt_bus ();

   logic imm;

   assign o_rreg0 = dec_bus.rs1_addr;
   assign o_rreg1 = dec_bus.rs2_addr;
   assign o_wreg0 = dec_bus.rd_addr;

   serv_state state_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .o_wen0     (o_wen0),
      .dec        (dec_bus),
      .cnt        (cnt_bus)
   );

   serv_decode decode_inst (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .dec        (dec_bus)
   );

   serv_immdec immdec_inst (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .dec        (dec_bus),
      .cnt        (cnt_bus),
      .o_imm      (imm)
   );

   serv_alu alu_inst (
      .clk   (clk),
      .i_rs1 (i_rdata0),
      .i_rs2 (i_rdata1),
      .i_imm (imm),
      .dec   (dec_bus),
      .cnt   (cnt_bus),
      .o_rd  (o_wdata0)
   );

   serv_ctrl ctrl_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .cnt        (cnt_bus),
      .o_ibus_adr (o_ibus_adr)
   );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the serv testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f flist.f --top-module serv_tb -Mdir obj_dir -o serv_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/serv_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
exit 0

// File: tests/serv_tb.sv
`timescale 1ns/100ps
`include "serv_params.svh"

module serv_tb;

   localparam int N_TESTS        = 17;
   localparam int TIMEOUT_CYCLES = N_TESTS * 48 + 20;

   logic                clk;
   logic                i_rst_n;
   serv_pkg::word_t     o_ibus_adr;
   logic                o_ibus_cyc;
   serv_pkg::word_t     i_ibus_rdt;
   logic                i_ibus_ack;
   logic                o_rf_rreq;
   logic                i_rf_ready;
   serv_pkg::reg_addr_t o_rreg0;
   serv_pkg::reg_addr_t o_rreg1;
   serv_pkg::reg_addr_t o_wreg0;
   logic                i_rdata0;
   logic                i_rdata1;
   logic                o_wen0;
   logic                o_wdata0;

   serv_pkg::word_t instr_tab [N_TESTS];
   string           name_tab  [N_TESTS];
   // Register file model and the golden copy
   serv_pkg::word_t rf   [32];
   serv_pkg::word_t gold [32];
   logic [31:0]     lcg_state = 32'h11a;
   int              err_word  = 0;
   int              err_addr  = 0;
   int              err_reg   = 0;
   int              err_misc  = 0;
   int              cycles    = 0;

   serv_top serv_top_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .o_wreg0    (o_wreg0),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Zero to three wait cycles
   function automatic int random_delay();
      logic [31:0] r;
      r = lcg_next();
      return int'(r[17:16]);
   endfunction

   function automatic serv_pkg::word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, `SERV_OP_REG, 2'b11};
   endfunction

   function automatic serv_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                             logic [4:0] rd, logic [4:0] op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic serv_pkg::word_t enc_u(logic [19:0] imm, logic [4:0] rd);
      return {imm, rd, `SERV_OP_LUI, 2'b11};
   endfunction

   function automatic serv_pkg::word_t alu_word(logic [2:0] f3, logic sub,
                                                serv_pkg::word_t a, serv_pkg::word_t b);
      case (f3)
         `SERV_F3_ADD: return sub ? a - b : a + b;
         `SERV_F3_XOR: return a ^ b;
         `SERV_F3_OR:  return a | b;
         `SERV_F3_AND: return a & b;
         default:      return '0;
      endcase
   endfunction

   function automatic logic model_writes(serv_pkg::word_t instr);
      logic ok;
      case (instr[6:2])
         `SERV_OP_REG, `SERV_OP_IMM: begin
            ok = (instr[14:12] == `SERV_F3_ADD) || (instr[14:12] == `SERV_F3_XOR) ||
                 (instr[14:12] == `SERV_F3_OR)  || (instr[14:12] == `SERV_F3_AND);
         end
         `SERV_OP_LUI: ok = 1'b1;
         default:      ok = 1'b0;
      endcase
      return ok && (instr[11:7] != 5'd0);
   endfunction

   function automatic serv_pkg::word_t model_result(serv_pkg::word_t instr,
                                                    serv_pkg::word_t a, serv_pkg::word_t b);
      serv_pkg::word_t imm;
      imm = {{20{instr[31]}}, instr[31:20]};
      case (instr[6:2])
         `SERV_OP_REG: return alu_word(instr[14:12], instr[30], a, b);
         `SERV_OP_IMM: return alu_word(instr[14:12], 1'b0, a, imm);
         `SERV_OP_LUI: return {instr[31:12], 12'h000};
         default:      return '0;
      endcase
   endfunction

   task automatic check_word(string name, serv_pkg::word_t exp, serv_pkg::word_t act);
      if (act !== exp) begin
         err_word++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(string name, serv_pkg::word_t exp, serv_pkg::word_t act);
      if (act !== exp) begin
         err_addr++;
         $display("Error %s: expected fetch address %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_reg(string name, serv_pkg::reg_addr_t exp, serv_pkg::reg_addr_t act);
      if (act !== exp) begin
         err_reg++;
         $display("Error %s: expected register %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic report_problem(string name, string msg);
      err_misc++;
      $display("%s: %s", name, msg);
   endtask

   task automatic load_table();
      instr_tab[0]  = enc_i(12'h001, 5'd0, `SERV_F3_ADD, 5'd7, `SERV_OP_IMM);
      name_tab[0]   = "addi_one";
      instr_tab[1]  = enc_r(7'h00, 5'd2, 5'd1, `SERV_F3_ADD, 5'd3);
      name_tab[1]   = "add";
      instr_tab[2]  = enc_r(7'h20, 5'd2, 5'd1, `SERV_F3_ADD, 5'd4);
      name_tab[2]   = "sub";
      // 0 - 1 borrows through every bit
      instr_tab[3]  = enc_r(7'h20, 5'd7, 5'd0, `SERV_F3_ADD, 5'd8);
      name_tab[3]   = "sub_borrow";
      instr_tab[4]  = enc_r(7'h00, 5'd2, 5'd1, `SERV_F3_XOR, 5'd9);
      name_tab[4]   = "xor";
      instr_tab[5]  = enc_r(7'h00, 5'd4, 5'd3, `SERV_F3_OR, 5'd10);
      name_tab[5]   = "or";
      instr_tab[6]  = enc_r(7'h00, 5'd9, 5'd1, `SERV_F3_AND, 5'd11);
      name_tab[6]   = "and";
      instr_tab[7]  = enc_i(12'hffb, 5'd1, `SERV_F3_ADD, 5'd12, `SERV_OP_IMM);
      name_tab[7]   = "addi_neg";
      instr_tab[8]  = enc_i(12'h7ff, 5'd2, `SERV_F3_ADD, 5'd13, `SERV_OP_IMM);
      name_tab[8]   = "addi_pos";
      instr_tab[9]  = enc_i(12'hfff, 5'd1, `SERV_F3_XOR, 5'd14, `SERV_OP_IMM);
      name_tab[9]   = "xori_neg";
      instr_tab[10] = enc_i(12'h0f0, 5'd2, `SERV_F3_OR, 5'd15, `SERV_OP_IMM);
      name_tab[10]  = "ori_pos";
      instr_tab[11] = enc_i(12'h800, 5'd8, `SERV_F3_AND, 5'd16, `SERV_OP_IMM);
      name_tab[11]  = "andi_neg";
      instr_tab[12] = enc_u(20'habcde, 5'd17);
      name_tab[12]  = "lui";
      instr_tab[13] = enc_r(7'h00, 5'd2, 5'd1, `SERV_F3_ADD, 5'd0);
      name_tab[13]  = "add_x0";
      instr_tab[14] = enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd18);
      name_tab[14]  = "sll_nop";
      instr_tab[15] = enc_i(12'h000, 5'd1, 3'b010, 5'd19, 5'b00000);
      name_tab[15]  = "load_nop";
      instr_tab[16] = enc_i(12'h123, 5'd17, `SERV_F3_ADD, 5'd20, `SERV_OP_IMM);
      name_tab[16]  = "addi_after_lui";
   endtask

   // Starts and ends on a falling edge
   task automatic run_instr(int idx);
      serv_pkg::word_t     instr;
      serv_pkg::word_t     result;
      serv_pkg::word_t     expected;
      serv_pkg::reg_addr_t rs1a;
      serv_pkg::reg_addr_t rs2a;
      serv_pkg::reg_addr_t wreg;
      string               name;
      int                  wen_cnt;
      int                  d;
      instr   = instr_tab[idx];
      name    = name_tab[idx];
      result  = '0;
      wen_cnt = 0;
      while (!o_ibus_cyc) @(negedge clk);
      check_addr(name, `SERV_RESET_PC + serv_pkg::word_t'(4 * idx), o_ibus_adr);
      d = random_delay();
      repeat (d) begin
         @(negedge clk);
         if (!o_ibus_cyc) report_problem(name, "o_ibus_cyc dropped before the ack");
      end
      @(posedge clk);
      #1;
      i_ibus_ack = 1'b1;
      i_ibus_rdt = instr;
      @(posedge clk);
      #1;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      @(negedge clk);
      if (!o_rf_rreq) report_problem(name, "o_rf_rreq not high the cycle after the ack");
      while (!o_rf_rreq) @(negedge clk);
      if (o_ibus_cyc) report_problem(name, "o_ibus_cyc still high after the ack");
      rs1a = o_rreg0;
      rs2a = o_rreg1;
      wreg = o_wreg0;
      check_reg(name, instr[11:7], o_wreg0);
      check_reg({name, "_rs1"}, (instr[6:2] == `SERV_OP_LUI) ? 5'd0 : instr[19:15], o_rreg0);
      check_reg({name, "_rs2"}, instr[24:20], o_rreg1);
      @(posedge clk);
      #1;
      if (o_rf_rreq) report_problem(name, "o_rf_rreq stayed high for more than one cycle");
      d = random_delay();
      repeat (d) begin
         @(posedge clk);
         #1;
      end
      i_rf_ready = 1'b1;
      @(posedge clk);
      #1;
      i_rf_ready = 1'b0;
      for (int k = 0; k < 32; k++) begin
         i_rdata0 = rf[rs1a][k];
         i_rdata1 = rf[rs2a][k];
         @(negedge clk);
         if (o_wen0) begin
            wen_cnt++;
            result[k] = o_wdata0;
         end
         @(posedge clk);
         #1;
      end
      i_rdata0 = 1'b0;
      i_rdata1 = 1'b0;
      if (wen_cnt > 0 && wreg != 5'd0) begin
         rf[wreg] = result;
      end
      expected = model_result(instr, gold[instr[19:15]], gold[instr[24:20]]);
      if (model_writes(instr)) begin
         if (wen_cnt != 32) report_problem(name, "o_wen0 was not high for the whole run");
         check_word(name, expected, result);
         gold[instr[11:7]] = expected;
      end else if (wen_cnt != 0) begin
         report_problem(name, "o_wen0 was asserted for an instruction that writes nothing");
      end
      @(negedge clk);
      if (!o_ibus_cyc || o_wen0) begin
         report_problem(name, "fetch did not restart right after the 32-cycle run");
      end
   endtask

   initial begin
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
         end
      end
   end

   initial begin
      i_rst_n    = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0   = 1'b0;
      i_rdata1   = 1'b0;
      load_table();
      rf[0]   = '0;
      gold[0] = '0;
      for (int j = 1; j < 32; j++) begin
         rf[j]   = lcg_next();
         gold[j] = rf[j];
      end
      repeat (3) @(posedge clk);
      #1;
      i_rst_n = 1'b1;
      @(negedge clk);
      if (!o_ibus_cyc || o_rf_rreq || o_wen0) begin
         report_problem("reset", "after reset o_ibus_cyc must be high, o_rf_rreq and o_wen0 low");
      end
      for (int i = 0; i < N_TESTS; i++) begin
         run_instr(i);
      end
      while (!o_ibus_cyc) @(negedge clk);
      check_addr("next_fetch", `SERV_RESET_PC + serv_pkg::word_t'(4 * N_TESTS), o_ibus_adr);
      // Catches stray writes as well
      for (int j = 0; j < 32; j++) begin
         check_word($sformatf("regfile_x%0d", j), gold[j], rf[j]);
      end
      $display("Errors: result %0d, address %0d, register %0d, other %0d",
               err_word, err_addr, err_reg, err_misc);
      if (err_word + err_addr + err_reg + err_misc == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
